// File: list.f
+incdir+rtl
rtl/sram_wrapper_pkg.sv
rtl/sram_ctrl_fsm.sv
rtl/sram_burst_addr.sv
rtl/sram_write_lanes.sv
rtl/sram_macro.sv
rtl/sram_wrapper.sv
test/sram_wrapper_asserts.sv
test/sram_wrapper_tb.sv

// File: Bender.yml
package:
  name: sram_wrapper

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sram_wrapper_pkg.sv
      - rtl/sram_ctrl_fsm.sv
      - rtl/sram_burst_addr.sv
      - rtl/sram_write_lanes.sv
      - rtl/sram_macro.sv
      - rtl/sram_wrapper.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/sram_wrapper_asserts.sv
      - test/sram_wrapper_tb.sv

// File: test/sram_wrapper_tb.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_wrapper_tb;

    localparam int LIMIT = 200;

    logic        clk;
    logic        rst;
    logic [7:0]  awid;
    logic [31:0] awaddr;
    logic [3:0]  awlen;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [7:0]  bid;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [7:0]  rid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    // Byte-addressed reference memory
    logic [7:0] model [int];

    sram_wrapper dut0 (.*);

    bind sram_wrapper sram_wrapper_asserts u_asserts (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task timeout_fail(input string sig);
        $display("Timeout: %s never came high", sig);
        $display("** FAIL **");
        $fatal(1, "wait timed out");
    endtask

    // Protocol assertions on the bound checker
    always @(negedge clk) begin
        check("assertion failures", 32'd0, dut0.u_asserts.fail_cnt);
    end

    function automatic logic [31:0] model_word(input int word);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = model.exists(word * 4 + i) ? model[word * 4 + i] : 8'h00;
        end
        return w;
    endfunction

    // Lanes from strobe class and start offset, same for every beat
    function automatic logic [3:0] lane_mask(input logic [3:0] strb, input logic [1:0] off);
        if (strb == 4'b0001) begin
            return 4'b0001 << off;
        end else if (strb == 4'b0011) begin
            return off[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    task write_burst(input logic [7:0] id, input logic [31:0] addr, input logic [3:0] len,
                     input logic [3:0] strb);
        int tmo;
        int word;
        logic [3:0] mask;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awvalid = 1'b1;
        #1;
        check("arready with awvalid", 1'b0, arready);
        tmo = 0;
        while (!awready) begin
            @(negedge clk);
            #1;
            tmo++;
            if (tmo > LIMIT) timeout_fail("awready");
        end
        @(negedge clk);
        awvalid = 1'b0;
        mask = lane_mask(strb, addr[1:0]);
        for (int k = 0; k <= len; k++) begin
            repeat ($urandom % 3) @(negedge clk);
            wdata  = $urandom;
            wstrb  = strb;
            wlast  = (k == len);
            wvalid = 1'b1;
            #1;
            tmo = 0;
            while (!wready) begin
                @(negedge clk);
                #1;
                tmo++;
                if (tmo > LIMIT) timeout_fail("wready");
            end
            word = (addr[15:2] + k) & 14'h3fff;
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) model[word * 4 + i] = wdata[i*8 +: 8];
            end
            @(negedge clk);
            wvalid = 1'b0;
            wlast  = 1'b0;
        end
        tmo = 0;
        bready = $urandom % 2;
        #1;
        while (!(bvalid && bready)) begin
            @(negedge clk);
            bready = $urandom % 2;
            #1;
            tmo++;
            if (tmo > LIMIT) timeout_fail("bvalid");
        end
        check("bid", id, bid);
        check("bresp", `AXI_RESP_OKAY, bresp);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task read_burst(input logic [7:0] id, input logic [31:0] addr, input logic [3:0] len,
                    input bit stall);
        int tmo;
        int word;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arvalid = 1'b1;
        #1;
        tmo = 0;
        while (!arready) begin
            @(negedge clk);
            #1;
            tmo++;
            if (tmo > LIMIT) timeout_fail("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (int k = 0; k <= len; k++) begin
            rready = stall ? ($urandom % 2) : 1'b1;
            #1;
            tmo = 0;
            while (!(rvalid && rready)) begin
                @(negedge clk);
                rready = stall ? ($urandom % 2) : 1'b1;
                #1;
                tmo++;
                if (tmo > LIMIT) timeout_fail("rvalid");
            end
            word = (addr[15:2] + k) & 14'h3fff;
            check("rdata", model_word(word), rdata);
            check("rlast", (k == len), rlast);
            check("rid", id, rid);
            check("rresp", `AXI_RESP_OKAY, rresp);
            @(negedge clk);
            rready = 1'b0;
        end
        #1;
        check("rvalid after last beat", 1'b0, rvalid);
    endtask

    initial begin
        logic [31:0] base;
        logic [3:0]  len;
        logic [7:0]  id;
        logic [3:0]  n_off;
        logic [3:0]  n_len;
        logic [3:0]  strb;
        void'($urandom(32'hf136_d47c));
        rst     = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        #1;
        check("reset awready", 1'b1, awready);
        check("reset arready", 1'b1, arready);
        check("reset wready", 1'b0, wready);
        check("reset bvalid", 1'b0, bvalid);
        check("reset rvalid", 1'b0, rvalid);
        @(negedge clk);

        for (int t = 0; t < 40; t++) begin
            id   = $urandom;
            base = $urandom & 32'h0000_ffff;
            len  = $urandom % 16;
            write_burst(id, base, len, 4'hf);
            // Narrow writes inside the range just written
            if ($urandom % 2) begin
                n_off = $urandom % (len + 1);
                n_len = $urandom % (len - n_off + 1);
                strb  = ($urandom % 2) ? 4'b0001 : 4'b0011;
                write_burst(id + 1, {base[31:2] + n_off, 2'($urandom)}, n_len, strb);
            end
            read_burst(id + 2, base, len, t % 2);
        end

        // Same-cycle AW and AR
        for (int t = 0; t < 5; t++) begin
            id   = $urandom;
            base = $urandom & 32'h0000_fffc;
            len  = $urandom % 16;
            arid    = id + 8'h40;
            araddr  = base;
            arlen   = len;
            arvalid = 1'b1;
            write_burst(id, base, len, 4'hf);
            read_burst(id + 8'h40, base, len, 1'b1);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: test/sram_wrapper_asserts.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_wrapper_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      rvalid,
    input logic                      rready,
    input logic [`AXI_DATA_BITS-1:0] rdata,
    input logic [`AXI_IDS_BITS-1:0]  rid,
    input logic                      rlast,
    input logic                      bvalid,
    input logic                      bready
);

    // Failed assertions so far
    int unsigned fail_cnt;

    // R payload frozen while stalled
    property r_stable;
        @(posedge clk) disable iff (!rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rid) && $stable(rlast));
    endproperty

    property b_hold;
        @(posedge clk) disable iff (!rst)
        (bvalid && !bready) |=> bvalid;
    endproperty

    // One transaction at a time
    property rb_exclusive;
        @(posedge clk) disable iff (!rst)
        !(rvalid && bvalid);
    endproperty

    a_r_stable: assert property (r_stable) else begin
        fail_cnt++;
        $error("R channel changed while stalled");
    end
    a_b_hold: assert property (b_hold) else begin
        fail_cnt++;
        $error("BVALID dropped before BREADY");
    end
    a_rb_excl: assert property (rb_exclusive) else begin
        fail_cnt++;
        $error("RVALID and BVALID both high");
    end

endmodule

// File: rtl/sram_wrapper.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_wrapper (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXI_IDS_BITS-1:0]  awid,
    input  logic [`AXI_ADDR_BITS-1:0] awaddr,
    input  logic [`AXI_LEN_BITS-1:0]  awlen,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DATA_BITS-1:0] wdata,
    input  logic [`AXI_STRB_BITS-1:0] wstrb,
    input  logic                      wlast,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [`AXI_IDS_BITS-1:0]  bid,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXI_IDS_BITS-1:0]  arid,
    input  logic [`AXI_ADDR_BITS-1:0] araddr,
    input  logic [`AXI_LEN_BITS-1:0]  arlen,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXI_IDS_BITS-1:0]  rid,
    output logic [`AXI_DATA_BITS-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  logic                      rready
);

    logic                       req_load;
    logic                       req_is_write;
    logic                       beat_adv;
    logic                       beat_last;
    logic                       cs;
    logic                       oe;
    logic                       wr_en;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`AXI_IDS_BITS-1:0]   id;
    logic [1:0]                 byte_off;
    logic [`AXI_STRB_BITS-1:0]  web;

    // Response is always OKAY
    assign bresp = `AXI_RESP_OKAY;
    assign rresp = `AXI_RESP_OKAY;
    assign bid   = id;
    assign rid   = id;

    sram_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .wlast        (wlast),
        .bready       (bready),
        .arvalid      (arvalid),
        .rready       (rready),
        .beat_last    (beat_last),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .req_load     (req_load),
        .req_is_write (req_is_write),
        .beat_adv     (beat_adv),
        .cs           (cs),
        .oe           (oe),
        .wr_en        (wr_en)
    );

    sram_burst_addr u_addr (
        .clk          (clk),
        .rst          (rst),
        .req_load     (req_load),
        .req_is_write (req_is_write),
        .beat_adv     (beat_adv),
        .awid         (awid),
        .arid         (arid),
        .awaddr       (awaddr),
        .araddr       (araddr),
        .awlen        (awlen),
        .arlen        (arlen),
        .addr         (addr),
        .id           (id),
        .byte_off     (byte_off),
        .beat_last    (beat_last)
    );

    sram_write_lanes u_lanes (
        .wr_en    (wr_en),
        .wstrb    (wstrb),
        .byte_off (byte_off),
        .web      (web)
    );

    sram_macro u_sram (
        .clk     (clk),
        .cs      (cs),
        .oe      (oe),
        .addr    (addr),
        .di      (wdata),
        .web     (web),
        .do_data (rdata)
    );

endmodule

// File: rtl/sram_macro.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_macro (
    input  logic                       clk,
    input  logic                       cs,
    input  logic                       oe,
    input  logic [`SRAM_ADDR_BITS-1:0] addr,
    input  logic [`AXI_DATA_BITS-1:0]  di,
    input  logic [`AXI_STRB_BITS-1:0]  web,
    output logic [`AXI_DATA_BITS-1:0]  do_data
);

    localparam int unsigned DEPTH = 1 << `SRAM_ADDR_BITS;

    logic [`AXI_DATA_BITS-1:0] mem [DEPTH];
    logic [`AXI_DATA_BITS-1:0] do_q;

    always_ff @(posedge clk) begin
        if (cs) begin
            for (int i = 0; i < `AXI_STRB_BITS; i++) begin
                if (web[i] == sram_wrapper_pkg::WEB_ENB) begin
                    mem[addr][i*8 +: 8] <= di[i*8 +: 8];
                end
            end
            // Read returns the old word on a write cycle
            do_q <= mem[addr];
        end
    end

    assign do_data = oe ? do_q : '0;

endmodule

// File: rtl/sram_write_lanes.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_write_lanes (
    input  logic                      wr_en,
    input  logic [`AXI_STRB_BITS-1:0] wstrb,
    input  logic [1:0]                byte_off,
    output logic [`AXI_STRB_BITS-1:0] web
);

    always_comb begin
        web = {`AXI_STRB_BITS{sram_wrapper_pkg::WEB_DIS}};
        if (wr_en) begin
            case (wstrb)
                `AXI_STRB_BYTE: begin
                    web[byte_off] = sram_wrapper_pkg::WEB_ENB;
                end
                `AXI_STRB_HWORD: begin
                    // Lower or upper halfword
                    web[{byte_off[1], 1'b0} +: 2] = {2{sram_wrapper_pkg::WEB_ENB}};
                end
                default: begin
                    web = {`AXI_STRB_BITS{sram_wrapper_pkg::WEB_ENB}};
                end
            endcase
        end
    end

endmodule

// File: rtl/sram_burst_addr.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module sram_burst_addr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_load,
    input  logic                       req_is_write,
    input  logic                       beat_adv,
    input  logic [`AXI_IDS_BITS-1:0]   awid,
    input  logic [`AXI_IDS_BITS-1:0]   arid,
    input  logic [`AXI_ADDR_BITS-1:0]  awaddr,
    input  logic [`AXI_ADDR_BITS-1:0]  araddr,
    input  logic [`AXI_LEN_BITS-1:0]   awlen,
    input  logic [`AXI_LEN_BITS-1:0]   arlen,
    output logic [`SRAM_ADDR_BITS-1:0] addr,
    output logic [`AXI_IDS_BITS-1:0]   id,
    output logic [1:0]                 byte_off,
    output logic                       beat_last
);

    logic [`AXI_ADDR_BITS-1:0]  req_addr;
    logic [`SRAM_ADDR_BITS-1:0] base;
    logic [`AXI_LEN_BITS-1:0]   len;
    logic [`AXI_LEN_BITS-1:0]   cnt;
    logic [`SRAM_ADDR_BITS-1:0] cur_addr;
    logic                       wr_mode;

    assign req_addr = req_is_write ? awaddr : araddr;

    // Payload fields
    always_ff @(posedge clk) begin
        if (req_load) begin
            base     <= req_addr[`SRAM_ADDR_BITS+`SRAM_ADDR_LSB-1:`SRAM_ADDR_LSB];
            byte_off <= req_addr[`SRAM_ADDR_LSB-1:0];
            id       <= req_is_write ? awid : arid;
            len      <= req_is_write ? awlen : arlen;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt     <= '0;
            wr_mode <= 1'b0;
        end else if (req_load) begin
            cnt     <= '0;
            wr_mode <= req_is_write;
        end else if (beat_adv) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign cur_addr  = base + `SRAM_ADDR_BITS'(cnt);
    assign beat_last = (cnt == len);

    // Reads look one word ahead on the advance, writes use the current beat
    always_comb begin
        if (req_load) begin
            addr = req_addr[`SRAM_ADDR_BITS+`SRAM_ADDR_LSB-1:`SRAM_ADDR_LSB];
        end else if (beat_adv && !wr_mode) begin
            addr = cur_addr + 1'b1;
        end else begin
            addr = cur_addr;
        end
    end

endmodule

// File: rtl/sram_ctrl_fsm.sv
`timescale 1ns/1ps

module sram_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic awvalid,
    input  logic wvalid,
    input  logic wlast,
    input  logic bready,
    input  logic arvalid,
    input  logic rready,
    input  logic beat_last,
    output logic awready,
    output logic wready,
    output logic bvalid,
    output logic arready,
    output logic rvalid,
    output logic rlast,
    output logic req_load,
    output logic req_is_write,
    output logic beat_adv,
    output logic cs,
    output logic oe,
    output logic wr_en
);

    sram_wrapper_pkg::ctrl_state_t state;
    sram_wrapper_pkg::ctrl_state_t state_nxt;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    // Handshakes, only evaluated here
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;
    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sram_wrapper_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            sram_wrapper_pkg::IDLE: begin
                // Write wins a tie
                if (aw_hs) begin
                    state_nxt = sram_wrapper_pkg::WRITE;
                end else if (ar_hs) begin
                    state_nxt = sram_wrapper_pkg::READ;
                end
            end
            sram_wrapper_pkg::WRITE: begin
                if (w_hs && wlast) begin
                    state_nxt = sram_wrapper_pkg::RESP;
                end
            end
            sram_wrapper_pkg::RESP: begin
                if (b_hs) begin
                    state_nxt = sram_wrapper_pkg::IDLE;
                end
            end
            sram_wrapper_pkg::READ: begin
                if (r_hs && beat_last) begin
                    state_nxt = sram_wrapper_pkg::IDLE;
                end
            end
            default: state_nxt = sram_wrapper_pkg::IDLE;
        endcase
    end

    always_comb begin
        awready      = 1'b0;
        arready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        rvalid       = 1'b0;
        rlast        = 1'b0;
        req_load     = 1'b0;
        req_is_write = 1'b0;
        beat_adv     = 1'b0;
        cs           = 1'b0;
        oe           = 1'b0;
        wr_en        = 1'b0;
        case (state)
            sram_wrapper_pkg::IDLE: begin
                awready      = 1'b1;
                arready      = ~awvalid;
                req_load     = aw_hs | ar_hs;
                req_is_write = awvalid;
                // First read word is fetched on the AR edge
                cs           = ar_hs;
                oe           = ar_hs;
            end
            sram_wrapper_pkg::WRITE: begin
                wready   = 1'b1;
                wr_en    = w_hs;
                cs       = w_hs;
                beat_adv = w_hs;
            end
            sram_wrapper_pkg::RESP: begin
                bvalid = 1'b1;
            end
            sram_wrapper_pkg::READ: begin
                rvalid   = 1'b1;
                rlast    = beat_last;
                // Address held while stalled, so a re-read keeps rdata stable
                cs       = 1'b1;
                oe       = 1'b1;
                beat_adv = r_hs & ~beat_last;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/sram_wrapper_pkg.sv
package sram_wrapper_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10,
        RESP  = 2'b11
    } ctrl_state_t;

    // Byte write enables are active low
    localparam logic WEB_ENB = 1'b0;
    localparam logic WEB_DIS = 1'b1;

endpackage

// File: rtl/axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// AXI4 field widths
`define AXI_IDS_BITS   8
`define AXI_ADDR_BITS  32
`define AXI_LEN_BITS   4
`define AXI_DATA_BITS  32
`define AXI_STRB_BITS  4

// Strobe classes, anything else is a full word
`define AXI_STRB_BYTE  4'b0001
`define AXI_STRB_HWORD 4'b0011

// Response codes
`define AXI_RESP_OKAY  2'b00

// SRAM word address, byte address bits 15 to 2
`define SRAM_ADDR_BITS 14
`define SRAM_ADDR_LSB  2

`endif
